//--- ra_fifo_top.f
+incdir+sim
source/ra_fifo_cfg_pkg.sv
source/ra_fifo_types_pkg.sv
source/ra_fifo_ram.sv
source/ra_fifo_core.sv
source/pipeline_control.sv
source/ra_fifo_read_fwft.sv
source/ra_fifo_top.sv
sim/ra_fifo_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module ra_fifo_tb \
	-f ra_fifo_top.f \
	--Mdir obj_dir \
	-o ra_fifo_sim

sim_out=$(./obj_dir/ra_fifo_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q '^TESTBENCH PASSED$'; then
	exit 0
fi
exit 1

//--- sim/ra_fifo_tb_model.svh
// queue model of the ring; include inside a module that imports both ra_fifo packages.
`ifndef RA_FIFO_TB_MODEL_SVH
`define RA_FIFO_TB_MODEL_SVH

wr_word_t model_q[$]; // stored words, oldest first.

// a word seen on the write port goes to the tail.
function automatic void model_write(input wr_word_t word);
	model_q.push_back(word);
endfunction

// answers one request from the queue and then applies a pop.
// a request is answered before a write that lands on the same clock.
function automatic rd_rsp_t reference_response(input rd_req_t req);
	rd_rsp_t rsp;
	int      idx;

	idx      = int'(req.offset);
	rsp.user = req.user; // tag always comes back.
	if (idx < model_q.size()) begin
		rsp.hit  = 1'b1;
		rsp.data = model_q[idx];
		if (req.op == op_pop) begin
			for (int i = 0; i <= idx; i++) begin
				void'(model_q.pop_front()); // release through the read entry.
			end
		end
	end else begin
		rsp.hit  = 1'b0;
		rsp.data = '0; // miss, nothing released.
	end
	return rsp;
endfunction

`endif

//--- sim/ra_fifo_tb.sv
// single 8 ns clock; inputs change on the falling edge, every wait gives up after wait_limit cycles.
`timescale 1ns/1ps
`default_nettype none

module ra_fifo_tb
	import ra_fifo_cfg_pkg::*;
	import ra_fifo_types_pkg::*;
();

	localparam int wait_limit = 400; // cycles per wait.

	logic     clk;
	logic     rst_n;
	wr_word_t s_wr_data;
	logic     s_wr_valid;
	logic     s_wr_ready;
	rd_req_t  s_req;
	logic     s_req_valid;
	logic     s_req_ready;
	rd_rsp_t  m_rsp;
	logic     m_rsp_valid;
	logic     m_rsp_ready;

	rd_rsp_t  exp_q[$]; // expected responses in request order.
	wr_word_t words[$]; // words offered in the current test.
	string    cur_test;
	int       test_err;
	int       err_total;
	int       tests_run;
	int       tests_failed;
	int       req_total;
	int       rsp_total;
	bit       timed_out;
	bit       req_done;

	`include "ra_fifo_tb_model.svh"

	ra_fifo_top u_ra_fifo_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.s_wr_data   (s_wr_data),
		.s_wr_valid  (s_wr_valid),
		.s_wr_ready  (s_wr_ready),
		.s_req       (s_req),
		.s_req_valid (s_req_valid),
		.s_req_ready (s_req_ready),
		.m_rsp       (m_rsp),
		.m_rsp_valid (m_rsp_valid),
		.m_rsp_ready (m_rsp_ready)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	function automatic void count_error();
		test_err++;
		err_total++;
	endfunction

	function automatic void check_value(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("Error: %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
			count_error();
		end
	endfunction

	function automatic rd_req_t make_req(input int user, input int offset, input rd_op_e op);
		rd_req_t req;

		req.user   = user_width'(user);
		req.offset = addr_width'(offset);
		req.op     = op;
		return req;
	endfunction

	function automatic void start_test(input string name);
		cur_test = name;
		test_err = 0;
	endfunction

	function automatic void end_test();
		tests_run++;
		if (test_err == 0) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, test_err);
		end
	endfunction

	function automatic void report_timeout(input string what);
		$display("timeout in test %s while waiting for %s", cur_test, what);
		timed_out = 1'b1;
		count_error();
	endfunction

	// request and write transfers seen by the DUT feed the model.
	always @(posedge clk) begin
		if (rst_n) begin
			if (s_req_valid && s_req_ready) begin
				exp_q.push_back(reference_response(s_req)); // before any write of this clock.
				req_total++;
			end
			if (s_wr_valid && s_wr_ready) begin
				model_write(s_wr_data);
			end
		end
	end

	always @(posedge clk) begin : compare_rsp
		rd_rsp_t exp_rsp;

		if (rst_n && m_rsp_valid && m_rsp_ready) begin
			rsp_total++;
			assert (exp_q.size() > 0) else begin
				$display("test %s: a response arrived with no request outstanding", cur_test);
				count_error();
			end
			if (exp_q.size() > 0) begin
				exp_rsp = exp_q.pop_front();
				assert (m_rsp === exp_rsp) else begin
					$display("Error: %s: response %0d expected user %h hit %b data %h %s %h %b %h",
						cur_test, rsp_total, exp_rsp.user, exp_rsp.hit, exp_rsp.data,
						"actual user hit data", m_rsp.user, m_rsp.hit, m_rsp.data);
					count_error();
				end
			end
		end
	end

	task automatic write_word(input wr_word_t word);
		int waited;
		bit accepted;

		waited   = 0;
		accepted = 1'b0;
		@(negedge clk);
		s_wr_data  = word;
		s_wr_valid = 1'b1;
		while (!accepted && waited < wait_limit) begin
			@(posedge clk);
			accepted = s_wr_ready;
			waited++;
		end
		if (!accepted) begin
			report_timeout("s_wr_ready");
		end
		@(negedge clk);
		s_wr_valid = 1'b0;
	endtask

	// one write attempt lasting a single clock.
	task automatic try_write(input wr_word_t word, output bit accepted);
		@(negedge clk);
		s_wr_data  = word;
		s_wr_valid = 1'b1;
		@(posedge clk);
		accepted = s_wr_ready;
		@(negedge clk);
		s_wr_valid = 1'b0;
	endtask

	task automatic send_req(input rd_req_t req);
		int waited;
		bit accepted;

		waited   = 0;
		accepted = 1'b0;
		@(negedge clk);
		s_req       = req;
		s_req_valid = 1'b1;
		while (!accepted && waited < wait_limit) begin
			@(posedge clk);
			accepted = s_req_ready;
			waited++;
		end
		if (!accepted) begin
			report_timeout("s_req_ready");
		end
		@(negedge clk);
		s_req_valid = 1'b0;
	endtask

	task automatic wait_responses();
		int waited;

		waited = 0;
		while (exp_q.size() != 0 && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			report_timeout("outstanding responses");
		end
	endtask

	task automatic release_all();
		if (model_q.size() > 0) begin
			send_req(make_req(0, model_q.size() - 1, op_pop));
			wait_responses();
		end
	endtask

	// pop, then peek the new head so the DUT shows it too.
	task automatic pop_and_check(input int offset, input int head_idx);
		int size_before;

		size_before = model_q.size();
		send_req(make_req(offset, offset, op_pop));
		send_req(make_req(15, 0, op_peek));
		wait_responses();
		check_value("released entries", offset + 1, size_before - model_q.size());
		check_value("new head", int'(words[head_idx]), int'(model_q[0]));
	endtask

	task automatic random_writes(input int n);
		bit accepted;

		for (int i = 0; i < n; i++) begin
			if ($urandom % 4 != 0) begin
				try_write($urandom, accepted);
			end else begin
				@(negedge clk);
			end
		end
	endtask

	task automatic random_requests(input int n);
		for (int i = 0; i < n && !timed_out; i++) begin
			send_req(make_req(int'($urandom % 16), int'($urandom % 8),
				($urandom % 4 == 0) ? op_pop : op_peek));
		end
	endtask

	task automatic toggle_ready();
		int waited;

		waited = 0;
		while (!req_done && waited < 40 * wait_limit) begin
			@(negedge clk);
			m_rsp_ready = ($urandom % 2) == 1;
			waited++;
		end
		if (!req_done) begin
			report_timeout("end of the request stream");
		end
	endtask

	task automatic run_tests();
		int acc_cnt;
		int size_before;
		bit accepted;

		start_test("fill_and_peek");
		check_value("m_rsp_valid after reset", 0, int'(m_rsp_valid));
		check_value("s_wr_ready after reset", 1, int'(s_wr_ready));
		check_value("s_req_ready after reset", 1, int'(s_req_ready));
		for (int i = 0; i < 8; i++) begin
			words.push_back(32'hA500_0000 + i);
			write_word(words[i]);
		end
		for (int i = 0; i < 8; i++) begin
			send_req(make_req(i, i, op_peek));
		end
		send_req(make_req(8, 7, op_peek)); // still a hit if nothing was released.
		wait_responses();
		check_value("stored count", 8, model_q.size());
		for (int i = 0; i < 8; i++) begin
			check_value("stored word", int'(words[i]), int'(model_q[i]));
		end
		end_test();
		if (timed_out) begin
			return;
		end

		start_test("pops");
		pop_and_check(0, 1);
		pop_and_check(0, 2);
		pop_and_check(2, 5);
		end_test();
		if (timed_out) begin
			return;
		end

		start_test("misses");
		size_before = model_q.size();
		for (int i = size_before; i < fifo_depth; i++) begin
			send_req(make_req(i, i, (i % 2 == 0) ? op_pop : op_peek));
		end
		wait_responses();
		check_value("entries after misses", size_before, model_q.size());
		end_test();
		if (timed_out) begin
			return;
		end

		start_test("full_buffer");
		release_all();
		words.delete();
		acc_cnt = 0;
		for (int i = 0; i < 20; i++) begin
			words.push_back(32'hC000_0000 + i);
			try_write(words[i], accepted);
			if (accepted) begin
				acc_cnt++;
			end
		end
		check_value("accepted writes", fifo_depth, acc_cnt);
		check_value("s_wr_ready when full", 0, int'(s_wr_ready));
		for (int i = 0; i < fifo_depth; i++) begin
			check_value("stored word", int'(words[i]), int'(model_q[i]));
		end
		for (int i = 0; i < fifo_depth; i++) begin
			send_req(make_req(i, 0, op_pop)); // reads back oldest first.
		end
		wait_responses();
		check_value("entries after read back", 0, model_q.size());
		end_test();
		if (timed_out) begin
			return;
		end

		start_test("back_pressure");
		req_done = 1'b0;
		fork
			random_writes(120);
			begin
				random_requests(150);
				req_done = 1'b1;
			end
			toggle_ready();
		join
		@(negedge clk);
		m_rsp_ready = 1'b1;
		wait_responses();
		check_value("m_rsp_valid after drain", 0, int'(m_rsp_valid));
		check_value("responses against requests", req_total, rsp_total);
		end_test();
	endtask

	initial begin
		rst_n       = 1'b0;
		s_wr_data   = '0;
		s_wr_valid  = 1'b0;
		s_req       = '0;
		s_req_valid = 1'b0;
		m_rsp_ready = 1'b1;
		void'($urandom(21));
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		run_tests();

		$display("tests %0d, failed %0d, requests %0d, responses %0d, errors %0d",
			tests_run, tests_failed, req_total, rsp_total, err_total);
		if (err_total == 0 && !timed_out) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/pipeline_control.sv
// valid bits for a stalling pipeline of stages >= 1; the datapath registers live with the user.
`timescale 1ns/1ps
`default_nettype none

module pipeline_control
	import ra_fifo_types_pkg::*;
#(
	parameter int stages = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              s_valid,
	output logic              s_ready,
	output logic              m_valid,
	input  logic              m_ready,
	output logic [stages-1:0] stage_cke,
	output logic [stages-1:0] stage_valid,
	output logic              buffered
);

	logic [stages:0]   rdy;      // stage i may load.
	logic [stages-1:0] in_valid; // word offered to stage i.
	logic              take;
	stage_state_e      state;
	stage_state_e      state_next;

	// skid ready comes from a register only.
	assign rdy[stages] = (state != st_buffered);

	generate
		for (genvar i = 0; i < stages; i++) begin : g_stage
			if (i == 0) begin : g_first
				assign in_valid[i] = s_valid;
			end else begin : g_next
				assign in_valid[i] = stage_valid[i-1];
			end
			assign rdy[i]       = !stage_valid[i] || rdy[i+1];
			assign stage_cke[i] = rdy[i] && in_valid[i]; // loads real words only.
		end
	endgenerate

	assign s_ready = rdy[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_valid <= '0;
		end else begin
			for (int i = 0; i < stages; i++) begin
				if (rdy[i]) begin
					stage_valid[i] <= in_valid[i];
				end
			end
		end
	end

	assign take = stage_valid[stages-1] && rdy[stages];

	always_comb begin
		state_next = state;
		case (state)
			st_empty: begin
				if (take) begin
					state_next = st_valid;
				end
			end
			st_valid: begin
				if (take && !m_ready) begin
					state_next = st_buffered; // spare register catches it.
				end else if (!take && m_ready) begin
					state_next = st_empty;
				end
			end
			st_buffered: begin
				if (m_ready) begin
					state_next = st_valid;
				end
			end
			default: begin
				state_next = st_empty;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_empty;
		end else begin
			state <= state_next;
		end
	end

	assign m_valid  = (state != st_empty);
	assign buffered = (state == st_buffered);

	valid_held: assert property (@(posedge clk) disable iff (!rst_n)
		m_valid && !m_ready |=> m_valid);

endmodule

`default_nettype wire

//--- source/ra_fifo_cfg_pkg.sv
// sizes are fixed here; fifo_depth must stay a power of two and ptr_width one bit above addr_width.
`default_nettype none

package ra_fifo_cfg_pkg;

	// stored word.
	localparam int data_width = 32;

	// memory address, 16 entries.
	localparam int addr_width = 4;

	// pointers and count carry one extra bit so full and empty differ.
	localparam int ptr_width = addr_width + 1;

	// request tag echoed in the response.
	localparam int user_width = 4;

	localparam int fifo_depth = 1 << addr_width;

endpackage

`default_nettype wire

//--- source/ra_fifo_core.sv
// pointer keeper; a request sees writes from earlier cycles only, and a pop takes effect at once.
`timescale 1ns/1ps
`default_nettype none

module ra_fifo_core
	import ra_fifo_cfg_pkg::*;
	import ra_fifo_types_pkg::*;
#(
	parameter int dout_regs = 1
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  wr_word_t              s_wr_data,
	input  logic                  s_wr_valid,
	output logic                  s_wr_ready,
	output logic                  wr_en,
	output logic [addr_width-1:0] wr_addr,
	input  logic                  rd_en,
	input  logic                  rd_regcke,
	input  logic [addr_width-1:0] rd_offset,
	input  rd_op_e                rd_op,
	output logic [addr_width-1:0] rd_addr,
	output logic                  rd_hit
);

	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] head_ptr;
	logic [ptr_width-1:0] count;
	logic [ptr_width-1:0] rel_cnt;
	logic                 hit;
	logic                 pop_hit;
	logic                 hit_q;

	// the data itself goes straight to the memory.
	assign s_wr_ready = (count != ptr_width'(fifo_depth));
	assign wr_en      = s_wr_valid && s_wr_ready;
	assign wr_addr    = wr_ptr[addr_width-1:0];

	// offset maps onto the ring from the oldest entry.
	assign rd_addr = head_ptr[addr_width-1:0] + rd_offset;
	assign hit     = (ptr_width'(rd_offset) < count);
	assign pop_hit = rd_en && (rd_op == op_pop) && hit;
	assign rel_cnt = pop_hit ? ptr_width'(rd_offset) + ptr_width'(1) : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			head_ptr <= '0;
			count    <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + ptr_width'(1);
			end
			head_ptr <= head_ptr + rel_cnt; // release through the popped entry.
			count    <= count + ptr_width'(wr_en) - rel_cnt;
		end
	end

	// hit rides along with the memory read.
	always_ff @(posedge clk) begin
		if (rd_en) begin
			hit_q <= hit;
		end
	end

	generate
		if (dout_regs != 0) begin : g_hit_reg
			logic hit_qq;

			always_ff @(posedge clk) begin
				if (rd_regcke) begin
					hit_qq <= hit_q;
				end
			end
			assign rd_hit = hit_qq;
		end else begin : g_hit_direct
			assign rd_hit = hit_q;
		end
	endgenerate

	count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= ptr_width'(fifo_depth));

	ptr_match: assert property (@(posedge clk) disable iff (!rst_n)
		(wr_ptr - head_ptr) == count);

endmodule

`default_nettype wire

//--- source/ra_fifo_ram.sv
// one write and one read port on clk; read data is undefined until a location has been written.
`timescale 1ns/1ps
`default_nettype none

module ra_fifo_ram
	import ra_fifo_cfg_pkg::*;
	import ra_fifo_types_pkg::*;
#(
	parameter int dout_regs = 1
) (
	input  logic                  clk,
	input  logic                  wr_en,
	input  logic [addr_width-1:0] wr_addr,
	input  wr_word_t              wr_data,
	input  logic                  rd_en,
	input  logic                  rd_regcke,
	input  logic [addr_width-1:0] rd_addr,
	output wr_word_t              rd_data
);

	wr_word_t mem [fifo_depth];
	wr_word_t rd_q;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_q <= mem[rd_addr]; // data one cycle after rd_en.
		end
	end

	generate
		if (dout_regs != 0) begin : g_out_reg
			wr_word_t out_q;

			always_ff @(posedge clk) begin
				if (rd_regcke) begin
					out_q <= rd_q; // second stage of the read pipeline.
				end
			end
			assign rd_data = out_q;
		end else begin : g_no_out_reg
			assign rd_data = rd_q;
		end
	endgenerate

endmodule

`default_nettype wire

//--- source/ra_fifo_read_fwft.sv
// requests issue straight to the core; responses come back in request order, misses with zero data.
`timescale 1ns/1ps
`default_nettype none

module ra_fifo_read_fwft
	import ra_fifo_cfg_pkg::*;
	import ra_fifo_types_pkg::*;
#(
	parameter int dout_regs = 1
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rd_req_t               s_req,
	input  logic                  s_req_valid,
	output logic                  s_req_ready,
	output logic                  rd_en,
	output logic                  rd_regcke,
	output logic [addr_width-1:0] rd_offset,
	output rd_op_e                rd_op,
	input  wr_word_t              rd_data,
	input  logic                  rd_hit,
	output rd_rsp_t               m_rsp,
	output logic                  m_rsp_valid,
	input  logic                  m_rsp_ready
);

	logic [dout_regs:0]                 stage_cke;
	logic [dout_regs:0]                 stage_valid;
	logic                               buffered;
	logic [dout_regs:0][user_width-1:0] tag_q;
	logic                               in_take;
	rd_rsp_t                            sink_rsp;
	rd_rsp_t                            out_rsp;
	rd_rsp_t                            buf_rsp;

	pipeline_control #(
		.stages      (dout_regs + 1)
	) u_pipeline_control (
		.clk         (clk),
		.rst_n       (rst_n),
		.s_valid     (s_req_valid),
		.s_ready     (s_req_ready),
		.m_valid     (m_rsp_valid),
		.m_ready     (m_rsp_ready),
		.stage_cke   (stage_cke),
		.stage_valid (stage_valid),
		.buffered    (buffered)
	);

	assign rd_en     = stage_cke[0]; // only on a request transfer.
	assign rd_offset = s_req.offset;
	assign rd_op     = s_req.op;

	generate
		if (dout_regs != 0) begin : g_regcke
			assign rd_regcke = stage_cke[1];
		end else begin : g_no_regcke
			assign rd_regcke = 1'b0;
		end
	endgenerate

	// tag follows the memory pipeline.
	always_ff @(posedge clk) begin
		if (stage_cke[0]) begin
			tag_q[0] <= s_req.user;
		end
		for (int i = 1; i <= dout_regs; i++) begin
			if (stage_cke[i]) begin
				tag_q[i] <= tag_q[i-1];
			end
		end
	end

	assign sink_rsp.user = tag_q[dout_regs];
	assign sink_rsp.hit  = rd_hit;
	assign sink_rsp.data = rd_hit ? rd_data : '0;

	// skid data registers, steered by the control state.
	assign in_take = stage_valid[dout_regs] && !buffered;

	always_ff @(posedge clk) begin
		if (buffered && m_rsp_ready) begin
			out_rsp <= buf_rsp;
		end else if (in_take && (!m_rsp_valid || m_rsp_ready)) begin
			out_rsp <= sink_rsp;
		end
		if (in_take && m_rsp_valid && !m_rsp_ready) begin
			buf_rsp <= sink_rsp;
		end
	end

	assign m_rsp = out_rsp;

	rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
		m_rsp_valid && !m_rsp_ready |=> $stable(m_rsp));

endmodule

`default_nettype wire

//--- source/ra_fifo_top.sv
// single clock, synchronous rst_n; one output register in the memory, so dout_regs is 1 throughout.
`timescale 1ns/1ps
`default_nettype none

module ra_fifo_top
	import ra_fifo_cfg_pkg::*;
	import ra_fifo_types_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  wr_word_t s_wr_data,
	input  logic     s_wr_valid,
	output logic     s_wr_ready,
	input  rd_req_t  s_req,
	input  logic     s_req_valid,
	output logic     s_req_ready,
	output rd_rsp_t  m_rsp,
	output logic     m_rsp_valid,
	input  logic     m_rsp_ready
);

	logic                  wr_en;
	logic [addr_width-1:0] wr_addr;
	logic                  rd_en;
	logic                  rd_regcke;
	logic [addr_width-1:0] rd_offset;
	rd_op_e                rd_op;
	logic [addr_width-1:0] rd_addr;
	wr_word_t              rd_data;
	logic                  rd_hit;

	ra_fifo_core #(
		.dout_regs  (1)
	) u_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.s_wr_data  (s_wr_data),
		.s_wr_valid (s_wr_valid),
		.s_wr_ready (s_wr_ready),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.rd_en      (rd_en),
		.rd_regcke  (rd_regcke),
		.rd_offset  (rd_offset),
		.rd_op      (rd_op),
		.rd_addr    (rd_addr),
		.rd_hit     (rd_hit)
	);

	ra_fifo_ram #(
		.dout_regs (1)
	) u_ram (
		.clk       (clk),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (s_wr_data),
		.rd_en     (rd_en),
		.rd_regcke (rd_regcke),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	ra_fifo_read_fwft #(
		.dout_regs   (1)
	) u_read (
		.clk         (clk),
		.rst_n       (rst_n),
		.s_req       (s_req),
		.s_req_valid (s_req_valid),
		.s_req_ready (s_req_ready),
		.rd_en       (rd_en),
		.rd_regcke   (rd_regcke),
		.rd_offset   (rd_offset),
		.rd_op       (rd_op),
		.rd_data     (rd_data),
		.rd_hit      (rd_hit),
		.m_rsp       (m_rsp),
		.m_rsp_valid (m_rsp_valid),
		.m_rsp_ready (m_rsp_ready)
	);

endmodule

`default_nettype wire

//--- source/ra_fifo_types_pkg.sv
// shared types; widths come from ra_fifo_cfg_pkg, so a size change needs no edit here.
`default_nettype none

package ra_fifo_types_pkg;

	import ra_fifo_cfg_pkg::*;

	// read opcode.
	typedef enum logic {
		op_peek = 1'b0, // read only.
		op_pop  = 1'b1  // read, then release up to this entry.
	} rd_op_e;

	// skid buffer state in pipeline_control.
	typedef enum logic [1:0] {
		st_empty    = 2'd0,
		st_valid    = 2'd1, // output register holds a word.
		st_buffered = 2'd2  // output and spare register both hold one.
	} stage_state_e;

	typedef logic [data_width-1:0] wr_word_t;

	// read request, 9 bits.
	typedef struct packed {
		logic [user_width-1:0] user;
		logic [addr_width-1:0] offset; // counted from the oldest entry.
		rd_op_e                op;
	} rd_req_t;

	// read response, 37 bits.
	typedef struct packed {
		logic [user_width-1:0] user;
		logic                  hit;
		wr_word_t              data; // zero on a miss.
	} rd_rsp_t;

endpackage

`default_nettype wire
